/* hdl/mini_core.sv */
// Top level: ctrl, register file and execute stages wired together
`timescale 1ns/1ns
`include "mini_core_consts.svh"
`default_nettype none

module mini_core
import mini_core_pkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  logic        Ready,
    input  logic        InstrValidQ101H,
    input  var t_instr  InstrQ101H,
    input  logic [31:0] PcQ101H,
    // Write-back port
    output logic        WbEnQ105H,
    output logic [4:0]  WbDstQ105H,
    output logic [31:0] WbDataQ105H
);

t_ctrl_rf    CtrlRf;
t_ctrl_exe   CtrlExe;
logic [31:0] ImmediateQ101H;
logic [31:0] ImmediateQ102H;
logic [31:0] PcQ102H;           // No consumer in this subset
logic [31:0] RegRdData1Q102H;
logic [31:0] RegRdData2Q102H;
logic [31:0] RegWrDataQ105H;

// ---------------------------------------------------------
// Stages
// ---------------------------------------------------------
mini_core_ctrl mini_core_ctrl (
    .Clock           (Clock),
    .Reset           (Reset),
    .Ready           (Ready),
    .InstrValidQ101H (InstrValidQ101H),
    .InstrQ101H      (InstrQ101H),
    .ImmediateQ101H  (ImmediateQ101H),
    .CtrlRf          (CtrlRf),
    .CtrlExe         (CtrlExe)
);

mini_core_rf #(.RF_NUM_MSB(`MINI_CORE_RF_NUM_MSB)) mini_core_rf (
    .Clock           (Clock),
    .Ready           (Ready),
    .Ctrl            (CtrlRf),
    .PcQ101H         (PcQ101H),
    .ImmediateQ101H  (ImmediateQ101H),
    .RegWrDataQ105H  (RegWrDataQ105H),
    .PcQ102H         (PcQ102H),
    .ImmediateQ102H  (ImmediateQ102H),
    .RegRdData1Q102H (RegRdData1Q102H),
    .RegRdData2Q102H (RegRdData2Q102H)
);

mini_core_exe mini_core_exe (
    .Clock           (Clock),
    .Reset           (Reset),
    .Ready           (Ready),
    .Ctrl            (CtrlExe),
    .RegRdData1Q102H (RegRdData1Q102H),
    .RegRdData2Q102H (RegRdData2Q102H),
    .ImmediateQ102H  (ImmediateQ102H),
    .RegWrDataQ105H  (RegWrDataQ105H)
);

// Write-back port, same qualified enable as the register file write
assign WbEnQ105H   = CtrlRf.RegWrEnQ105H;
assign WbDstQ105H  = CtrlRf.RegDstQ105H;
assign WbDataQ105H = RegWrDataQ105H;

endmodule

`default_nettype wire

/* hdl/mini_core_consts.svh */
// Core constants: register count, data width, RV32I opcodes and function codes
`ifndef MINI_CORE_CONSTS_SVH
`define MINI_CORE_CONSTS_SVH
`default_nettype none

// Highest register index, 15 gives an RV32E-like file
`define MINI_CORE_RF_NUM_MSB     31
`define MINI_CORE_DATA_W         32

// Accepted major opcodes
`define MINI_CORE_OPCODE_OP      7'b0110011
`define MINI_CORE_OPCODE_OP_IMM  7'b0010011

// funct3 encodings, shared by OP and OP-IMM
`define MINI_CORE_FUNCT3_ADD_SUB 3'b000
`define MINI_CORE_FUNCT3_SLL     3'b001
`define MINI_CORE_FUNCT3_SLT     3'b010
`define MINI_CORE_FUNCT3_XOR     3'b100
`define MINI_CORE_FUNCT3_SRL     3'b101
`define MINI_CORE_FUNCT3_OR      3'b110
`define MINI_CORE_FUNCT3_AND     3'b111

// funct7 values, ALT selects SUB
`define MINI_CORE_FUNCT7_BASE    7'b0000000
`define MINI_CORE_FUNCT7_ALT     7'b0100000

`default_nettype wire
`endif

/* hdl/mini_core_ctrl.sv */
// Decode and control pipe: Q101H decode, control fields registered through Q105H
`timescale 1ns/1ns
`include "mini_core_consts.svh"
`default_nettype none

module mini_core_ctrl
import mini_core_pkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  logic        Ready,
    input  logic        InstrValidQ101H,
    input  var t_instr  InstrQ101H,
    output logic [31:0] ImmediateQ101H,
    output t_ctrl_rf    CtrlRf,
    output t_ctrl_exe   CtrlExe
);

// Q101H decode
logic       IsOpQ101H;
logic       IsOpImmQ101H;
logic       SupportedQ101H;
logic       ValidQ101H;
t_alu_op    AluOpQ101H;
logic [4:0] RegSrc2Q101H;

// Stage registers
t_alu_op    AluOpQ102H;
logic       UseImmQ102H;
logic [4:0] RegSrc1Q102H;
logic [4:0] RegSrc2Q102H;
logic [4:0] RegDstQ102H;
logic [4:0] RegDstQ103H;
logic [4:0] RegDstQ104H;
logic [4:0] RegDstQ105H;
logic       RegWrEnQ102H;
logic       RegWrEnQ103H;
logic       RegWrEnQ104H;
logic       RegWrEnQ105H;

// ---------------------------------------------------------
// Q101H decode
// ---------------------------------------------------------
assign IsOpQ101H    = (InstrQ101H.R.Opcode == `MINI_CORE_OPCODE_OP);
assign IsOpImmQ101H = (InstrQ101H.I.Opcode == `MINI_CORE_OPCODE_OP_IMM);

always_comb begin
    AluOpQ101H     = ALU_ADD;
    SupportedQ101H = 1'b0;
    if (IsOpQ101H) begin
        SupportedQ101H = 1'b1;
        case (InstrQ101H.R.Funct3)
            `MINI_CORE_FUNCT3_ADD_SUB: begin
                AluOpQ101H = (InstrQ101H.R.Funct7 == `MINI_CORE_FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
            end
            `MINI_CORE_FUNCT3_SLL: AluOpQ101H = ALU_SLL;
            `MINI_CORE_FUNCT3_SLT: AluOpQ101H = ALU_SLT;
            `MINI_CORE_FUNCT3_XOR: AluOpQ101H = ALU_XOR;
            `MINI_CORE_FUNCT3_SRL: AluOpQ101H = ALU_SRL;
            `MINI_CORE_FUNCT3_OR:  AluOpQ101H = ALU_OR;
            `MINI_CORE_FUNCT3_AND: AluOpQ101H = ALU_AND;
            default:               SupportedQ101H = 1'b0;   // SLTU
        endcase
        // Alternate funct7 only legal on SUB, so SRA drops out here
        if ((InstrQ101H.R.Funct7 != `MINI_CORE_FUNCT7_BASE) &&
            !((InstrQ101H.R.Funct7 == `MINI_CORE_FUNCT7_ALT) &&
              (InstrQ101H.R.Funct3 == `MINI_CORE_FUNCT3_ADD_SUB))) begin
            SupportedQ101H = 1'b0;
        end
    end else if (IsOpImmQ101H) begin
        SupportedQ101H = 1'b1;
        case (InstrQ101H.I.Funct3)
            `MINI_CORE_FUNCT3_ADD_SUB: AluOpQ101H = ALU_ADD;
            `MINI_CORE_FUNCT3_SLT:     AluOpQ101H = ALU_SLT;
            `MINI_CORE_FUNCT3_XOR:     AluOpQ101H = ALU_XOR;
            `MINI_CORE_FUNCT3_OR:      AluOpQ101H = ALU_OR;
            `MINI_CORE_FUNCT3_AND:     AluOpQ101H = ALU_AND;
            default:                   SupportedQ101H = 1'b0;   // Immediate shifts, SLTIU
        endcase
    end
end

// Anything else turns into a bubble
assign ValidQ101H = InstrValidQ101H && SupportedQ101H;

// Sign-extended I-type immediate
assign ImmediateQ101H = {{20{InstrQ101H.I.Imm[11]}}, InstrQ101H.I.Imm};

// No second source read for I-type
assign RegSrc2Q101H = IsOpImmQ101H ? 5'b0 : InstrQ101H.R.Rs2;

// ---------------------------------------------------------
// Pipe registers Q102H..Q105H
// ---------------------------------------------------------
// Valid and write enables
always_ff @(posedge Clock) begin
    if (Reset) begin
        RegWrEnQ102H <= 1'b0;
        RegWrEnQ103H <= 1'b0;
        RegWrEnQ104H <= 1'b0;
        RegWrEnQ105H <= 1'b0;
    end else if (Ready) begin
        RegWrEnQ102H <= ValidQ101H;
        RegWrEnQ103H <= RegWrEnQ102H;
        RegWrEnQ104H <= RegWrEnQ103H;
        RegWrEnQ105H <= RegWrEnQ104H;
    end
end

// Payload fields
always_ff @(posedge Clock) begin
    if (Ready) begin
        AluOpQ102H   <= AluOpQ101H;
        UseImmQ102H  <= IsOpImmQ101H;
        RegSrc1Q102H <= InstrQ101H.R.Rs1;
        RegSrc2Q102H <= RegSrc2Q101H;
        RegDstQ102H  <= InstrQ101H.R.Rd;
        RegDstQ103H  <= RegDstQ102H;
        RegDstQ104H  <= RegDstQ103H;
        RegDstQ105H  <= RegDstQ104H;
    end
end

// ---------------------------------------------------------
// Outgoing control
// ---------------------------------------------------------
always_comb begin
    CtrlRf.RegSrc1Q101H = InstrQ101H.R.Rs1;
    CtrlRf.RegSrc2Q101H = RegSrc2Q101H;
    CtrlRf.RegDstQ105H  = RegDstQ105H;
    // Frozen Q105H writes once, when Ready comes back
    CtrlRf.RegWrEnQ105H = RegWrEnQ105H && Ready;
    // Spare bit
    CtrlRf.ValidQ101H   = 1'b0;

    CtrlExe.AluOpQ102H   = AluOpQ102H;
    CtrlExe.UseImmQ102H  = UseImmQ102H;
    CtrlExe.RegSrc1Q102H = RegSrc1Q102H;
    CtrlExe.RegSrc2Q102H = RegSrc2Q102H;
    CtrlExe.RegDstQ103H  = RegDstQ103H;
    CtrlExe.RegDstQ104H  = RegDstQ104H;
    CtrlExe.RegDstQ105H  = RegDstQ105H;
    CtrlExe.RegWrEnQ103H = RegWrEnQ103H;
    CtrlExe.RegWrEnQ104H = RegWrEnQ104H;
    CtrlExe.RegWrEnQ105H = RegWrEnQ105H;
end

// Write-back enable known once out of reset
aWbEnKnown: assert property (@(posedge Clock) disable iff (Reset)
    !$isunknown(RegWrEnQ105H))
    else $error("mini_core_ctrl: Q105H write enable unknown");

endmodule

`default_nettype wire

/* hdl/mini_core_exe.sv */
// Execute stage: operand forwarding, ALU, Q103H..Q105H result registers
`timescale 1ns/1ns
`include "mini_core_consts.svh"
`default_nettype none

module mini_core_exe
import mini_core_pkg::*;
(
    input  logic          Clock,
    input  logic          Reset,
    input  logic          Ready,
    input  var t_ctrl_exe Ctrl,
    input  logic [31:0]   RegRdData1Q102H,
    input  logic [31:0]   RegRdData2Q102H,
    input  logic [31:0]   ImmediateQ102H,
    output logic [31:0]   RegWrDataQ105H
);

logic [`MINI_CORE_DATA_W-1:0] Src1FwdQ102H;
logic [`MINI_CORE_DATA_W-1:0] Src2FwdQ102H;
logic [`MINI_CORE_DATA_W-1:0] AluSrc2Q102H;
logic [`MINI_CORE_DATA_W-1:0] AluResultQ102H;
logic [`MINI_CORE_DATA_W-1:0] AluResultQ103H;
logic [`MINI_CORE_DATA_W-1:0] AluResultQ104H;
logic [4:0]                   ShamtQ102H;

// ---------------------------------------------------------
// Forwarding
// ---------------------------------------------------------
// Youngest producer wins, x0 never forwarded
function automatic logic [`MINI_CORE_DATA_W-1:0] fwdOperand(
    input logic [4:0]                   Src,
    input logic [`MINI_CORE_DATA_W-1:0] RdData
);
    logic [`MINI_CORE_DATA_W-1:0] Operand;
    Operand = RdData;
    if (Src != 5'b0) begin
        if (Ctrl.RegWrEnQ103H && (Ctrl.RegDstQ103H == Src)) begin
            Operand = AluResultQ103H;
        end else if (Ctrl.RegWrEnQ104H && (Ctrl.RegDstQ104H == Src)) begin
            Operand = AluResultQ104H;
        end else if (Ctrl.RegWrEnQ105H && (Ctrl.RegDstQ105H == Src)) begin
            // Write landed after this consumer's Q101H read
            Operand = RegWrDataQ105H;
        end
    end
    return Operand;
endfunction

always_comb begin
    Src1FwdQ102H = fwdOperand(Ctrl.RegSrc1Q102H, RegRdData1Q102H);
    Src2FwdQ102H = fwdOperand(Ctrl.RegSrc2Q102H, RegRdData2Q102H);
end

// Immediate replaces rs2 for OP-IMM
assign AluSrc2Q102H = Ctrl.UseImmQ102H ? ImmediateQ102H : Src2FwdQ102H;
assign ShamtQ102H   = AluSrc2Q102H[4:0];

// ---------------------------------------------------------
// ALU, Q102H
// ---------------------------------------------------------
always_comb begin
    case (Ctrl.AluOpQ102H)
        ALU_ADD: AluResultQ102H = Src1FwdQ102H + AluSrc2Q102H;
        ALU_SUB: AluResultQ102H = Src1FwdQ102H - AluSrc2Q102H;
        ALU_AND: AluResultQ102H = Src1FwdQ102H & AluSrc2Q102H;
        ALU_OR:  AluResultQ102H = Src1FwdQ102H | AluSrc2Q102H;
        ALU_XOR: AluResultQ102H = Src1FwdQ102H ^ AluSrc2Q102H;
        ALU_SLL: AluResultQ102H = Src1FwdQ102H << ShamtQ102H;
        ALU_SRL: AluResultQ102H = Src1FwdQ102H >> ShamtQ102H;
        // Signed compare
        ALU_SLT: begin
            AluResultQ102H = {{(`MINI_CORE_DATA_W-1){1'b0}},
                              ($signed(Src1FwdQ102H) < $signed(AluSrc2Q102H))};
        end
        default: AluResultQ102H = '0;
    endcase
end

// ---------------------------------------------------------
// Result pipe Q103H..Q105H
// ---------------------------------------------------------
always_ff @(posedge Clock) begin
    if (Ready) begin
        AluResultQ103H <= AluResultQ102H;
        AluResultQ104H <= AluResultQ103H;
        RegWrDataQ105H <= AluResultQ104H;
    end
end

// Operands that moved into Q103H as a writing instruction were known
aOperandsKnown: assert property (@(posedge Clock) disable iff (Reset)
    (Ready ##1 Ctrl.RegWrEnQ103H) |-> !$isunknown({$past(Src1FwdQ102H), $past(AluSrc2Q102H)}))
    else $error("mini_core_exe: unknown forwarded operand");

endmodule

`default_nettype wire

/* hdl/mini_core_pkg.sv */
// Package: instruction union, ALU operation enum, per-stage control structs
`default_nettype none

package mini_core_pkg;

    // ---------------------------------------------------------
    // Instruction word views
    // ---------------------------------------------------------
    // R-type layout
    typedef struct packed {
        logic [6:0] Funct7;
        logic [4:0] Rs2;
        logic [4:0] Rs1;
        logic [2:0] Funct3;
        logic [4:0] Rd;
        logic [6:0] Opcode;
    } t_instr_r;

    // I-type layout, imm replaces funct7 and rs2
    typedef struct packed {
        logic [11:0] Imm;
        logic [4:0]  Rs1;
        logic [2:0]  Funct3;
        logic [4:0]  Rd;
        logic [6:0]  Opcode;
    } t_instr_i;

    // One 32-bit word, two decodes
    typedef union packed {
        t_instr_r R;
        t_instr_i I;
    } t_instr;

    // ---------------------------------------------------------
    // ALU operations
    // ---------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } t_alu_op;

    // ---------------------------------------------------------
    // Stage control
    // ---------------------------------------------------------
    // Register file control, 17 bits
    typedef struct packed {
        logic [4:0] RegSrc1Q101H;
        logic [4:0] RegSrc2Q101H;
        logic [4:0] RegDstQ105H;
        logic       RegWrEnQ105H;   // Already qualified by Ready
        logic       ValidQ101H;     // Spare padding bit
    } t_ctrl_rf;

    // Execute control, enables here are the raw stored ones
    typedef struct packed {
        t_alu_op    AluOpQ102H;
        logic       UseImmQ102H;
        logic [4:0] RegSrc1Q102H;
        logic [4:0] RegSrc2Q102H;
        logic [4:0] RegDstQ103H;
        logic [4:0] RegDstQ104H;
        logic [4:0] RegDstQ105H;
        logic       RegWrEnQ103H;
        logic       RegWrEnQ104H;
        logic       RegWrEnQ105H;
    } t_ctrl_exe;

endpackage

`default_nettype wire

/* hdl/mini_core_rf.sv */
// Register file: x0 tie-off, Q105H-to-Q101H write forwarding, Q102H operand registers
`timescale 1ns/1ns
`include "mini_core_consts.svh"
`default_nettype none

module mini_core_rf
import mini_core_pkg::*;
#(parameter int RF_NUM_MSB = `MINI_CORE_RF_NUM_MSB)
(
    input  logic         Clock,
    input  logic         Ready,
    // Control path
    input  var t_ctrl_rf Ctrl,
    // Data path in
    input  logic [31:0]  PcQ101H,
    input  logic [31:0]  ImmediateQ101H,
    input  logic [31:0]  RegWrDataQ105H,
    // Data path out
    output logic [31:0]  PcQ102H,
    output logic [31:0]  ImmediateQ102H,
    output logic [31:0]  RegRdData1Q102H,
    output logic [31:0]  RegRdData2Q102H
);

// x0 has no storage
logic [`MINI_CORE_DATA_W-1:0] Register [1:RF_NUM_MSB];
logic                         MatchRd1AftrWrQ101H;
logic                         MatchRd2AftrWrQ101H;
logic [`MINI_CORE_DATA_W-1:0] RegRdData1Q101H;
logic [`MINI_CORE_DATA_W-1:0] RegRdData2Q101H;

// ---------------------------------------------------------
// Write port, lands at the edge ending Q105H
// ---------------------------------------------------------
always_ff @(posedge Clock) begin
    if (Ctrl.RegWrEnQ105H && (Ctrl.RegDstQ105H != 5'b0)) begin
        Register[Ctrl.RegDstQ105H] <= RegWrDataQ105H;
    end
end

// ---------------------------------------------------------
// Read ports, Q101H
// ---------------------------------------------------------
// Same-cycle write bypass
assign MatchRd1AftrWrQ101H = (Ctrl.RegSrc1Q101H == Ctrl.RegDstQ105H) && Ctrl.RegWrEnQ105H;
assign MatchRd2AftrWrQ101H = (Ctrl.RegSrc2Q101H == Ctrl.RegDstQ105H) && Ctrl.RegWrEnQ105H;

always_comb begin
    // x0 first, so an x0 producer is never bypassed
    if (Ctrl.RegSrc1Q101H == 5'b0) begin
        RegRdData1Q101H = '0;
    end else if (MatchRd1AftrWrQ101H) begin
        RegRdData1Q101H = RegWrDataQ105H;
    end else begin
        RegRdData1Q101H = Register[Ctrl.RegSrc1Q101H];
    end

    if (Ctrl.RegSrc2Q101H == 5'b0) begin
        RegRdData2Q101H = '0;
    end else if (MatchRd2AftrWrQ101H) begin
        RegRdData2Q101H = RegWrDataQ105H;
    end else begin
        RegRdData2Q101H = Register[Ctrl.RegSrc2Q101H];
    end
end

// ---------------------------------------------------------
// Q102H registers
// ---------------------------------------------------------
always_ff @(posedge Clock) begin
    if (Ready) begin
        PcQ102H         <= PcQ101H;
        ImmediateQ102H  <= ImmediateQ101H;
        RegRdData1Q102H <= RegRdData1Q101H;
        RegRdData2Q102H <= RegRdData2Q101H;
    end
end

// Array only takes known data
aWrDataKnown: assert property (@(posedge Clock)
    (Ctrl.RegWrEnQ105H && (Ctrl.RegDstQ105H != 5'b0)) |-> !$isunknown(RegWrDataQ105H))
    else $error("mini_core_rf: unknown write data for x%0d", Ctrl.RegDstQ105H);

endmodule

`default_nettype wire

/* mini_core.f */
+incdir+hdl
hdl/mini_core_pkg.sv
hdl/mini_core_ctrl.sv
hdl/mini_core_rf.sv
hdl/mini_core_exe.sv
hdl/mini_core.sv
sim/mini_core_tb.sv

/* run.sh */
#!/bin/sh
# Build the mini_core testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module mini_core_tb -f mini_core.f -o mini_core_sim

out=$(./obj_dir/mini_core_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test OK'; then
    exit 0
fi
exit 1

/* sim/mini_core_tb.sv */
// Testbench for mini_core: stimulus table, reference register model, write-back checks
`timescale 1ns/1ns
`include "mini_core_consts.svh"
`default_nettype none

module mini_core_tb
import mini_core_pkg::*;
;

typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SRA, OP_LOAD
} t_test_op;

// One table row
typedef struct packed {
    logic [2:0]  Group;
    t_test_op    Op;
    logic [4:0]  Rd;
    logic [4:0]  Rs1;
    logic [4:0]  Rs2;
    logic [11:0] Imm;
    logic        Stall;     // Random Ready-low gap before issue
    logic        Valid;
} t_row;

// Pending write-back, Stamp is the Ready-high count at issue
typedef struct packed {
    logic [4:0]  Dst;
    logic [31:0] Data;
    logic [31:0] Stamp;
} t_expect;

logic        Clock;
logic        Reset;
logic        Ready;
logic        InstrValidQ101H;
t_instr      InstrQ101H;
logic [31:0] PcQ101H;
logic        WbEnQ105H;
logic [4:0]  WbDstQ105H;
logic [31:0] WbDataQ105H;

t_row        Rows [$];
t_expect     ExpQ [$];
logic [31:0] Model [0:31];
logic [31:0] ReadyHigh;
logic [31:0] Pc;
integer      Seed;
int          TestChecks;
int          TestErrors;
int          TotalChecks;
int          TotalErrors;
int          TestCount;
string       TestName [1:5];

mini_core dut (
    .Clock           (Clock),
    .Reset           (Reset),
    .Ready           (Ready),
    .InstrValidQ101H (InstrValidQ101H),
    .InstrQ101H      (InstrQ101H),
    .PcQ101H         (PcQ101H),
    .WbEnQ105H       (WbEnQ105H),
    .WbDstQ105H      (WbDstQ105H),
    .WbDataQ105H     (WbDataQ105H)
);

initial begin
    Clock = 1'b0;
    forever begin
        #10;
        Clock = ~Clock;
    end
end

// ------------------------------------------------------------
// Encoder and reference model
// ------------------------------------------------------------
function automatic logic isImmOp(input t_test_op Op);
    return Op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI};
endfunction

function automatic logic [31:0] encodeInstr(input t_row Row);
    logic [6:0] Funct7;
    logic [2:0] Funct3;
    logic [6:0] Opcode;
    Funct7 = `MINI_CORE_FUNCT7_BASE;
    Funct3 = `MINI_CORE_FUNCT3_ADD_SUB;
    Opcode = isImmOp(Row.Op) ? `MINI_CORE_OPCODE_OP_IMM : `MINI_CORE_OPCODE_OP;
    case (Row.Op)
        OP_SUB:          Funct7 = `MINI_CORE_FUNCT7_ALT;
        OP_AND, OP_ANDI: Funct3 = `MINI_CORE_FUNCT3_AND;
        OP_OR, OP_ORI:   Funct3 = `MINI_CORE_FUNCT3_OR;
        OP_XOR, OP_XORI: Funct3 = `MINI_CORE_FUNCT3_XOR;
        OP_SLL:          Funct3 = `MINI_CORE_FUNCT3_SLL;
        OP_SRL:          Funct3 = `MINI_CORE_FUNCT3_SRL;
        OP_SLT, OP_SLTI: Funct3 = `MINI_CORE_FUNCT3_SLT;
        // SRA is not in the subset
        OP_SRA: begin
            Funct3 = `MINI_CORE_FUNCT3_SRL;
            Funct7 = `MINI_CORE_FUNCT7_ALT;
        end
        // LW opcode, never accepted
        OP_LOAD:         Opcode = 7'b0000011;
        default:         Funct3 = `MINI_CORE_FUNCT3_ADD_SUB;
    endcase
    if (Opcode == `MINI_CORE_OPCODE_OP) begin
        return {Funct7, Row.Rs2, Row.Rs1, Funct3, Row.Rd, Opcode};
    end else begin
        return {Row.Imm, Row.Rs1, Funct3, Row.Rd, Opcode};
    end
endfunction

// RV32I result rules
function automatic logic [31:0] refResult(input t_test_op Op, input logic [31:0] A,
                                          input logic [31:0] B);
    case (Op)
        OP_ADD, OP_ADDI: return A + B;
        OP_SUB:          return A - B;
        OP_AND, OP_ANDI: return A & B;
        OP_OR, OP_ORI:   return A | B;
        OP_XOR, OP_XORI: return A ^ B;
        OP_SLL:          return A << B[4:0];
        OP_SRL:          return A >> B[4:0];
        OP_SLT, OP_SLTI: return {31'b0, $signed(A) < $signed(B)};
        default:         return 32'b0;
    endcase
endfunction

task automatic addRow(input int Group, input t_test_op Op, input int Rd, input int Rs1,
                      input int Rs2, input int Imm, input int Stall, input int Valid);
    t_row Row;
    Row.Group = Group[2:0];
    Row.Op    = Op;
    Row.Rd    = Rd[4:0];
    Row.Rs1   = Rs1[4:0];
    Row.Rs2   = Rs2[4:0];
    Row.Imm   = Imm[11:0];
    Row.Stall = (Stall != 0);
    Row.Valid = (Valid != 0);
    Rows.push_back(Row);
endtask

// ------------------------------------------------------------
// Cycle driver and write-back monitor
// ------------------------------------------------------------
task automatic countError();
    TestErrors = TestErrors + 1;
endtask

task automatic checkWriteBack(input logic ReadyIn);
    t_expect Front;
    assert (!$isunknown(WbEnQ105H)) else begin
        $display("write-back enable is unknown at %0t", $time);
        countError();
    end
    if (WbEnQ105H === 1'b1) begin
        TestChecks = TestChecks + 1;
        assert (ExpQ.size() != 0) else begin
            $display("unexpected write-back to x%0d at %0t", WbDstQ105H, $time);
            countError();
        end
        if (ExpQ.size() != 0) begin
            Front = ExpQ.pop_front();
            assert (WbDstQ105H === Front.Dst && WbDataQ105H === Front.Data) else begin
                $display("mismatch at %0t: got x%0d=%h, expected x%0d=%h", $time,
                         WbDstQ105H, WbDataQ105H, Front.Dst, Front.Data);
                countError();
            end
            assert ((ReadyHigh - Front.Stamp) == 32'd4) else begin
                $display("write-back of x%0d came %0d Ready-high cycles after issue, not 4",
                         Front.Dst, ReadyHigh - Front.Stamp);
                countError();
            end
        end
    end else if (ReadyIn && ExpQ.size() != 0) begin
        // Oldest result is due once it has seen four Ready-high cycles
        assert ((ReadyHigh - ExpQ[0].Stamp) < 32'd4) else begin
            $display("write-back of x%0d is missing at %0t", ExpQ[0].Dst, $time);
            countError();
            Front = ExpQ.pop_front();
        end
    end
endtask

// Drive on the falling edge, sample halfway to the rising edge
task automatic stepCycle(input logic ReadyIn, input logic ValidIn, input logic [31:0] InstrIn,
                         input logic Issue, input logic [4:0] Dst, input logic [31:0] Data);
    t_expect Entry;
    @(negedge Clock);
    Ready           = ReadyIn;
    InstrValidQ101H = ValidIn;
    InstrQ101H      = InstrIn;
    PcQ101H         = Pc;
    #5;
    if (ReadyIn) begin
        ReadyHigh = ReadyHigh + 32'd1;
    end
    checkWriteBack(ReadyIn);
    if (ReadyIn && ValidIn) begin
        Pc = Pc + 32'd4;
    end
    if (ReadyIn && Issue) begin
        Entry.Dst   = Dst;
        Entry.Data  = Data;
        Entry.Stamp = ReadyHigh;
        ExpQ.push_back(Entry);
    end
endtask

task automatic drainPipeline();
    int Waited;
    Waited = 0;
    while (ExpQ.size() != 0 && Waited < 20) begin
        stepCycle(1'b1, 1'b0, 32'b0, 1'b0, 5'b0, 32'b0);
        Waited = Waited + 1;
    end
    if (ExpQ.size() != 0) begin
        $display("timeout: %0d write-backs still pending after %0d idle cycles",
                 ExpQ.size(), Waited);
        countError();
        ExpQ.delete();
    end
    // Quiet tail catches late or repeated write-backs
    repeat (5) stepCycle(1'b1, 1'b0, 32'b0, 1'b0, 5'b0, 32'b0);
endtask

task automatic finishTest(input logic [2:0] Group);
    drainPipeline();
    $display("test %0d (%s): %0d checks, %0d errors", Group, TestName[Group],
             TestChecks, TestErrors);
    TotalChecks = TotalChecks + TestChecks;
    TotalErrors = TotalErrors + TestErrors;
    TestCount   = TestCount + 1;
    TestChecks  = 0;
    TestErrors  = 0;
endtask

// ------------------------------------------------------------
// Stimulus table
// ------------------------------------------------------------
task automatic fillTable();
    // Group, op, rd, rs1, rs2, imm, stall, valid
    addRow(1, OP_ADDI, 1, 0, 0, 2047, 0, 1);
    addRow(1, OP_ADDI, 2, 0, 0, -123, 0, 1);
    addRow(1, OP_ADDI, 3, 0, 0, 37, 0, 1);
    addRow(1, OP_ADDI, 4, 0, 0, -2048, 0, 1);
    addRow(1, OP_ADD, 5, 1, 2, 0, 0, 1);
    addRow(1, OP_SUB, 6, 2, 1, 0, 0, 1);
    addRow(1, OP_AND, 7, 1, 2, 0, 0, 1);
    addRow(1, OP_OR, 8, 4, 2, 0, 0, 1);
    addRow(1, OP_XOR, 9, 1, 4, 0, 0, 1);
    // Shift amount 37 masks to 5
    addRow(1, OP_SLL, 10, 1, 3, 0, 0, 1);
    addRow(1, OP_SRL, 11, 2, 3, 0, 0, 1);
    addRow(1, OP_SLT, 12, 2, 1, 0, 0, 1);
    addRow(1, OP_SLT, 13, 1, 2, 0, 0, 1);
    addRow(1, OP_ANDI, 14, 2, 0, -16, 0, 1);
    addRow(1, OP_ORI, 15, 1, 0, -2048, 0, 1);
    addRow(1, OP_XORI, 16, 2, 0, -1, 0, 1);
    addRow(1, OP_SLTI, 17, 2, 0, 1, 0, 1);
    addRow(1, OP_SLTI, 18, 1, 0, -256, 0, 1);
    // Consumers at distance 1..4 from x25
    addRow(2, OP_ADDI, 25, 0, 0, 7, 0, 1);
    addRow(2, OP_ADDI, 26, 25, 0, 1, 0, 1);
    addRow(2, OP_ADDI, 27, 25, 0, 2, 0, 1);
    addRow(2, OP_ADDI, 28, 25, 0, 3, 0, 1);
    addRow(2, OP_ADDI, 29, 25, 0, 4, 0, 1);
    addRow(2, OP_ADD, 30, 25, 26, 0, 0, 1);
    addRow(2, OP_SLL, 31, 29, 25, 0, 0, 1);
    // x0 written, then read at distance 1..3
    addRow(3, OP_ADDI, 0, 1, 0, 5, 0, 1);
    addRow(3, OP_ADD, 19, 0, 0, 0, 0, 1);
    addRow(3, OP_ADDI, 19, 0, 0, 9, 0, 1);
    addRow(3, OP_OR, 18, 0, 1, 0, 0, 1);
    addRow(3, OP_SUB, 0, 2, 1, 0, 0, 1);
    addRow(3, OP_XOR, 17, 0, 2, 0, 0, 1);
    // Bubbles between real writes
    addRow(4, OP_ADDI, 5, 0, 0, 77, 0, 1);
    addRow(4, OP_ADDI, 5, 0, 0, 1, 0, 0);
    addRow(4, OP_SRA, 5, 2, 3, 0, 0, 1);
    addRow(4, OP_LOAD, 5, 1, 0, 0, 0, 1);
    addRow(4, OP_ADD, 6, 5, 5, 0, 0, 1);
    addRow(4, OP_XOR, 7, 6, 1, 0, 0, 0);
    addRow(4, OP_XOR, 7, 6, 1, 0, 0, 1);
    // Dependent chain under random Ready-low gaps
    addRow(5, OP_ADDI, 8, 0, 0, 3, 1, 1);
    addRow(5, OP_ADD, 9, 8, 8, 0, 1, 1);
    addRow(5, OP_SUB, 10, 9, 8, 0, 0, 1);
    addRow(5, OP_SLL, 11, 10, 8, 0, 1, 1);
    addRow(5, OP_ADDI, 8, 11, 0, -1, 1, 1);
    addRow(5, OP_SLT, 12, 8, 11, 0, 0, 1);
    addRow(5, OP_OR, 13, 12, 9, 0, 1, 1);
    addRow(5, OP_ADDI, 0, 13, 0, 4, 1, 1);
    addRow(5, OP_XORI, 14, 0, 0, 85, 1, 1);
endtask

// ------------------------------------------------------------
// Main sequence
// ------------------------------------------------------------
initial begin
    t_row        Row;
    logic [31:0] Instr;
    logic [31:0] OpB;
    logic [31:0] Res;
    logic        WillWrite;
    logic [2:0]  CurGroup;
    int          Gap;
    int          G;
    int          I;
    Reset           = 1'b1;
    Ready           = 1'b1;
    InstrValidQ101H = 1'b0;
    InstrQ101H      = '0;
    PcQ101H         = '0;
    Pc              = '0;
    ReadyHigh       = '0;
    Seed            = 32'h4e31_bbb6;
    TestChecks      = 0;
    TestErrors      = 0;
    TotalChecks     = 0;
    TotalErrors     = 0;
    TestCount       = 0;
    CurGroup        = 3'd0;
    TestName[1]     = "all ALU operations";
    TestName[2]     = "back-to-back dependencies";
    TestName[3]     = "register x0";
    TestName[4]     = "latency and bubbles";
    TestName[5]     = "random stalls";
    for (I = 0; I < 32; I++) begin
        Model[I] = 32'b0;
    end
    fillTable();
    repeat (16) @(negedge Clock);
    Reset = 1'b0;

    for (I = 0; I < Rows.size(); I++) begin
        Row = Rows[I];
        if (Row.Group != CurGroup) begin
            if (CurGroup != 3'd0) begin
                finishTest(CurGroup);
            end
            CurGroup = Row.Group;
        end
        Instr = encodeInstr(Row);
        // Instruction waits at Q101H while Ready is low
        if (Row.Stall) begin
            Gap = $unsigned($random(Seed)) % 4;
            for (G = 0; G < Gap; G++) begin
                stepCycle(1'b0, Row.Valid, Instr, 1'b0, 5'b0, 32'b0);
            end
        end
        WillWrite = Row.Valid && !(Row.Op inside {OP_SRA, OP_LOAD});
        OpB = isImmOp(Row.Op) ? {{20{Row.Imm[11]}}, Row.Imm} : Model[Row.Rs2];
        Res = refResult(Row.Op, Model[Row.Rs1], OpB);
        if (WillWrite && Row.Rd != 5'd0) begin
            Model[Row.Rd] = Res;
        end
        stepCycle(1'b1, Row.Valid, Instr, WillWrite, Row.Rd, Res);
    end
    finishTest(CurGroup);

    $display("%0d tests, %0d checks, %0d errors", TestCount, TotalChecks, TotalErrors);
    if (TotalErrors == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire
